/* hw/ScoreboardPkg.sv */
package ScoreboardPkg;

    localparam int RegCount = 16;
    localparam int StackReg = 14;            // Stack pointer, tracked by its own unit
    localparam int RegAddrW = $clog2(RegCount);

    typedef logic [RegAddrW-1:0] RegAddrT;
    typedef logic [RegCount-1:0] RegVecT;    // One bit per register

    // Operand queued for read
    typedef struct packed {
        logic    readingFromA;
        logic    willBeWritingToA;
        logic    markADirty;
        RegVecT  readAOneHot;                // Predecoded by the register file
        logic    readingFromB;
        RegAddrT readBAddress;
    } ReadReqT;

    // Operands leaving the issue slots
    typedef struct packed {
        logic    issuedFromA;
        RegAddrT issueAAddress;
        logic    issuedFromB;
        RegAddrT issueBAddress;
    } IssueReqT;

    // Results coming back from the load/store unit and writeback
    typedef struct packed {
        logic   loadingToReg;
        RegVecT loadingOneHot;
        logic   writingToReg;
        RegVecT writingOneHot;
    } RetireReqT;

    typedef struct packed {
        logic stackAdjust;
        logic stackWriteback;
        logic stackRead;
        logic stackIssue;
    } StackReqT;

endpackage : ScoreboardPkg

/* hw/RegisterStateCell.sv */
`timescale 1ns/1ps

module RegisterStateCell (
    input  logic clk,
    input  logic clkEn,
    input  logic rst,

    input  logic usedAsA,
    input  logic willBeWritingToA,
    input  logic markDirty,
    input  logic usedAsB,
    input  logic issuedAsA,
    input  logic issuedAsB,
    input  logic dirtyB,
    input  logic loadValid,
    input  logic writebackValid,

    output logic dirty,
    output logic toBeWritten,
    output logic toBeRead
);

    logic readSet;
    logic readClear;
    logic writeSet;
    logic dirtySet;
    logic writeClear;

    assign readSet = usedAsA || usedAsB;
    // Issue as A is a replay while the B operand is still dirty
    assign readClear = issuedAsB || (issuedAsA && !dirtyB);

    assign writeSet   = willBeWritingToA;
    assign dirtySet   = markDirty && willBeWritingToA;
    assign writeClear = loadValid || writebackValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            dirty       <= 1'b0;
            toBeWritten <= 1'b0;
            toBeRead    <= 1'b0;
        end else if (clkEn) begin
            // Set beats clear in every flag
            if (readSet) begin
                toBeRead <= 1'b1;
            end else if (readClear) begin
                toBeRead <= 1'b0;
            end

            if (writeSet) begin
                toBeWritten <= 1'b1;
            end else if (writeClear) begin
                toBeWritten <= 1'b0;
            end

            if (dirtySet) begin
                dirty <= 1'b1;
            end else if (writeClear) begin
                dirty <= 1'b0;
            end
        end
    end

    // A writeback must retire a write announced earlier
    assert property (@(posedge clk) disable iff (rst)
        (clkEn && writebackValid) |-> toBeWritten)
    else $error("Writeback to a register with no pending write");

endmodule : RegisterStateCell

/* hw/StackStatus.sv */
`timescale 1ns/1ps

module StackStatus #(
    parameter int StackDepth = 4
) (
    input  logic                    clk,
    input  logic                    clkEn,
    input  logic                    rst,

    input  ScoreboardPkg::StackReqT stackReq,

    output logic                    stackDirty,
    output logic                    stackToBeWritten,
    output logic                    stackToBeRead
);

    localparam int CountW = $clog2(StackDepth + 1);

    logic [CountW-1:0] adjustCount;  // Pending stack pointer adjustments
    logic              countUp;
    logic              countDown;

    // Adjust and writeback together cancel out
    assign countUp   = stackReq.stackAdjust && !stackReq.stackWriteback;
    assign countDown = stackReq.stackWriteback && !stackReq.stackAdjust;

    always_ff @(posedge clk) begin
        if (rst) begin
            adjustCount <= '0;
        end else if (clkEn) begin
            if (countUp) begin
                adjustCount <= adjustCount + 1'b1;
            end else if (countDown) begin
                adjustCount <= adjustCount - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stackToBeRead <= 1'b0;
        end else if (clkEn) begin
            if (stackReq.stackRead) begin
                stackToBeRead <= 1'b1;   // Set wins
            end else if (stackReq.stackIssue) begin
                stackToBeRead <= 1'b0;
            end
        end
    end

    assign stackToBeWritten = adjustCount != '0;
    // Second adjustment in flight makes the pointer value stale
    assign stackDirty = adjustCount >= CountW'(2);

    assert property (@(posedge clk) disable iff (rst)
        (clkEn && countUp) |-> adjustCount < CountW'(StackDepth))
    else $error("Stack adjustment counter overflows StackDepth");

    assert property (@(posedge clk) disable iff (rst)
        (clkEn && countDown) |-> adjustCount != '0)
    else $error("Stack writeback with no pending adjustment");

endmodule : StackStatus

/* hw/HazardCheck.sv */
`timescale 1ns/1ps

module HazardCheck (
    input  ScoreboardPkg::RegAddrT waitA,
    input  ScoreboardPkg::RegAddrT waitB,
    input  logic                   waitAValid,
    input  logic                   waitBValid,

    input  ScoreboardPkg::RegVecT  dirtyVector,
    input  ScoreboardPkg::RegVecT  toBeWrittenVector,

    output logic                   stallA,
    output logic                   stallB
);

    logic waitAPending;
    logic waitBPending;
    logic waitBDirty;

    // Status of the source registers held in each slot
    assign waitAPending = toBeWrittenVector[waitA];
    assign waitBPending = toBeWrittenVector[waitB];
    assign waitBDirty   = dirtyVector[waitB];

    assign stallA = waitAValid && waitAPending;       // RAW on A
    // B also waits on a register that is dirty
    assign stallB = waitBValid && (waitBPending || waitBDirty);

endmodule : HazardCheck

/* hw/RegisterStatus.sv */
`timescale 1ns/1ps

module RegisterStatus (
    input  logic                     clk,
    input  logic                     clkEn,
    input  logic                     rst,

    input  ScoreboardPkg::ReadReqT   readReq,
    input  ScoreboardPkg::IssueReqT  issueReq,
    input  ScoreboardPkg::RetireReqT retireReq,

    input  logic                     stackDirty,
    input  logic                     stackToBeWritten,
    input  logic                     stackToBeRead,

    output ScoreboardPkg::RegVecT    dirtyVector,
    output ScoreboardPkg::RegVecT    toBeWrittenVector,
    output ScoreboardPkg::RegVecT    toBeReadVector
);

    import ScoreboardPkg::*;

    RegVecT readBOneHot;
    RegVecT issueAOneHot;
    RegVecT issueBOneHot;
    logic   dirtyB;

    always_comb begin
        readBOneHot = '0;
        readBOneHot[readReq.readBAddress] = 1'b1;
    end

    always_comb begin
        issueAOneHot = '0;
        issueAOneHot[issueReq.issueAAddress] = 1'b1;
    end

    always_comb begin
        issueBOneHot = '0;
        issueBOneHot[issueReq.issueBAddress] = 1'b1;
    end

    // B operand leaving now is still dirty
    assign dirtyB = issueReq.issuedFromB && |(issueBOneHot & dirtyVector);

    for (genvar r = 0; r < RegCount; r++) begin : regGen
        if (r == StackReg) begin : stackSlot
            assign dirtyVector[r]       = stackDirty;
            assign toBeWrittenVector[r] = stackToBeWritten;
            assign toBeReadVector[r]    = stackToBeRead;
        end else begin : generalSlot
            logic usedAsA;
            logic willBeWritingToA;
            logic markDirty;
            logic usedAsB;
            logic issuedAsA;
            logic issuedAsB;
            logic loadValid;
            logic writebackValid;

            assign usedAsA          = readReq.readingFromA && readReq.readAOneHot[r];
            assign willBeWritingToA = usedAsA && readReq.willBeWritingToA;
            assign markDirty        = usedAsA && readReq.markADirty;
            assign usedAsB          = readReq.readingFromB && readBOneHot[r];
            assign issuedAsA        = issueReq.issuedFromA && issueAOneHot[r];
            assign issuedAsB        = issueReq.issuedFromB && issueBOneHot[r];
            assign loadValid        = retireReq.loadingToReg && retireReq.loadingOneHot[r];
            assign writebackValid   = retireReq.writingToReg && retireReq.writingOneHot[r];

            RegisterStateCell RegisterStateCell_i (
                .clk             (clk),
                .clkEn           (clkEn),
                .rst             (rst),
                .usedAsA         (usedAsA),
                .willBeWritingToA(willBeWritingToA),
                .markDirty       (markDirty),
                .usedAsB         (usedAsB),
                .issuedAsA       (issuedAsA),
                .issuedAsB       (issuedAsB),
                .dirtyB          (dirtyB),
                .loadValid       (loadValid),
                .writebackValid  (writebackValid),
                .dirty           (dirtyVector[r]),
                .toBeWritten     (toBeWrittenVector[r]),
                .toBeRead        (toBeReadVector[r])
            );
        end
    end

    // Register file hands over a single predecoded A operand
    assert property (@(posedge clk) disable iff (rst)
        (clkEn && readReq.readingFromA) |-> $onehot(readReq.readAOneHot))
    else $error("readAOneHot is not one-hot on a read as A");

endmodule : RegisterStatus

/* hw/ScoreboardTop.sv */
`timescale 1ns/1ps

module ScoreboardTop #(
    parameter int StackDepth = 4
) (
    input  logic                     clk,
    input  logic                     clkEn,
    input  logic                     rst,

    input  ScoreboardPkg::ReadReqT   readReq,
    input  ScoreboardPkg::IssueReqT  issueReq,
    input  ScoreboardPkg::RetireReqT retireReq,
    input  ScoreboardPkg::StackReqT  stackReq,

    input  ScoreboardPkg::RegAddrT   waitA,
    input  ScoreboardPkg::RegAddrT   waitB,
    input  logic                     waitAValid,
    input  logic                     waitBValid,

    output ScoreboardPkg::RegVecT    dirtyVector,
    output ScoreboardPkg::RegVecT    toBeWrittenVector,
    output ScoreboardPkg::RegVecT    toBeReadVector,

    output logic                     stallA,
    output logic                     stallB
);

    // Register 14 flags from the stack unit
    logic stackDirty;
    logic stackToBeWritten;
    logic stackToBeRead;

    StackStatus #(
        .StackDepth(StackDepth)
    ) StackStatus_i (
        .clk             (clk),
        .clkEn           (clkEn),
        .rst             (rst),
        .stackReq        (stackReq),
        .stackDirty      (stackDirty),
        .stackToBeWritten(stackToBeWritten),
        .stackToBeRead   (stackToBeRead)
    );

    RegisterStatus RegisterStatus_i (
        .clk              (clk),
        .clkEn            (clkEn),
        .rst              (rst),
        .readReq          (readReq),
        .issueReq         (issueReq),
        .retireReq        (retireReq),
        .stackDirty       (stackDirty),
        .stackToBeWritten (stackToBeWritten),
        .stackToBeRead    (stackToBeRead),
        .dirtyVector      (dirtyVector),
        .toBeWrittenVector(toBeWrittenVector),
        .toBeReadVector   (toBeReadVector)
    );

    // Stalls follow the vectors in the same cycle
    HazardCheck HazardCheck_i (
        .waitA            (waitA),
        .waitB            (waitB),
        .waitAValid       (waitAValid),
        .waitBValid       (waitBValid),
        .dirtyVector      (dirtyVector),
        .toBeWrittenVector(toBeWrittenVector),
        .stallA           (stallA),
        .stallB           (stallB)
    );

endmodule : ScoreboardTop

/* testbench/ScoreboardTb.sv */
`timescale 1ns/1ps

module ScoreboardTb;

    import ScoreboardPkg::*;

    localparam int ClkHalf    = 4;
    localparam int StackDepth = 4;
    localparam int FieldCount = 29;           // Name plus 28 numeric columns

    // One line of the test file
    typedef struct packed {
        logic      clkEn;
        ReadReqT   readReq;
        IssueReqT  issueReq;
        RetireReqT retireReq;
        StackReqT  stackReq;
        RegAddrT   waitA;
        logic      waitAValid;
        RegAddrT   waitB;
        logic      waitBValid;
        RegVecT    expDirty;
        RegVecT    expToBeWritten;
        RegVecT    expToBeRead;
        logic      expStallA;
        logic      expStallB;
    } StepT;

    logic      clk;
    logic      clkEn;
    logic      rst;
    ReadReqT   readReq;
    IssueReqT  issueReq;
    RetireReqT retireReq;
    StackReqT  stackReq;
    RegAddrT   waitA;
    RegAddrT   waitB;
    logic      waitAValid;
    logic      waitBValid;
    RegVecT    dirtyVector;
    RegVecT    toBeWrittenVector;
    RegVecT    toBeReadVector;
    logic      stallA;
    logic      stallB;

    string stepNames[$];
    StepT  steps[$];
    int    cycleCount = 0;
    int    cycleLimit = 0;
    bit    loaded     = 1'b0;

    ScoreboardTop #(
        .StackDepth(StackDepth)
    ) ScoreboardTop_i (
        .clk              (clk),
        .clkEn            (clkEn),
        .rst              (rst),
        .readReq          (readReq),
        .issueReq         (issueReq),
        .retireReq        (retireReq),
        .stackReq         (stackReq),
        .waitA            (waitA),
        .waitB            (waitB),
        .waitAValid       (waitAValid),
        .waitBValid       (waitBValid),
        .dirtyVector      (dirtyVector),
        .toBeWrittenVector(toBeWrittenVector),
        .toBeReadVector   (toBeReadVector),
        .stallA           (stallA),
        .stallB           (stallB)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #ClkHalf clk = ~clk;
        end
    end

    task automatic checkValue(input string testName, input string what,
                              input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s expected %h actual %h", testName, what, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic loadTests();
        int    fd;
        int    got;
        int    f[FieldCount-1];
        string line;
        string name;
        StepT  s;
        fd = $fopen("testbench/scoreboard_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file testbench/scoreboard_tests.txt");
            $display("Errors found");
            $fatal(1);
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;                     // Comment or blank
            end
            got = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                f[20], f[21], f[22], f[23], f[24], f[25], f[26], f[27]);
            if (got != FieldCount) begin
                $display("Malformed line in the test file: %s", line);
                $display("Errors found");
                $fatal(1);
            end
            s.clkEn                      = f[0][0];
            s.readReq.readingFromA       = f[1][0];
            s.readReq.willBeWritingToA   = f[2][0];
            s.readReq.markADirty         = f[3][0];
            s.readReq.readAOneHot        = f[4][15:0];
            s.readReq.readingFromB       = f[5][0];
            s.readReq.readBAddress       = f[6][3:0];
            s.issueReq.issuedFromA       = f[7][0];
            s.issueReq.issueAAddress     = f[8][3:0];
            s.issueReq.issuedFromB       = f[9][0];
            s.issueReq.issueBAddress     = f[10][3:0];
            s.retireReq.loadingToReg     = f[11][0];
            s.retireReq.loadingOneHot    = f[12][15:0];
            s.retireReq.writingToReg     = f[13][0];
            s.retireReq.writingOneHot    = f[14][15:0];
            s.stackReq.stackAdjust       = f[15][0];
            s.stackReq.stackWriteback    = f[16][0];
            s.stackReq.stackRead         = f[17][0];
            s.stackReq.stackIssue        = f[18][0];
            s.waitA                      = f[19][3:0];
            s.waitAValid                 = f[20][0];
            s.waitB                      = f[21][3:0];
            s.waitBValid                 = f[22][0];
            s.expDirty                   = f[23][15:0];
            s.expToBeWritten             = f[24][15:0];
            s.expToBeRead                = f[25][15:0];
            s.expStallA                  = f[26][0];
            s.expStallB                  = f[27][0];
            stepNames.push_back(name);
            steps.push_back(s);
        end
        $fclose(fd);
        if (steps.size() == 0) begin
            $display("The test file holds no test steps");
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic applyStep(input StepT s);
        clkEn      <= s.clkEn;
        readReq    <= s.readReq;
        issueReq   <= s.issueReq;
        retireReq  <= s.retireReq;
        stackReq   <= s.stackReq;
        waitA      <= s.waitA;
        waitAValid <= s.waitAValid;
        waitB      <= s.waitB;
        waitBValid <= s.waitBValid;
    endtask

    // Events off, wait inputs kept for the stall check
    task automatic applyIdle();
        clkEn     <= 1'b1;
        readReq   <= '0;
        issueReq  <= '0;
        retireReq <= '0;
        stackReq  <= '0;
    endtask

    task automatic checkStep(input string testName, input StepT s);
        checkValue(testName, "dirtyVector", s.expDirty, dirtyVector);
        checkValue(testName, "toBeWrittenVector", s.expToBeWritten, toBeWrittenVector);
        checkValue(testName, "toBeReadVector", s.expToBeRead, toBeReadVector);
        checkValue(testName, "stallA", {15'd0, s.expStallA}, {15'd0, stallA});
        checkValue(testName, "stallB", {15'd0, s.expStallB}, {15'd0, stallB});
    endtask

    always @(posedge clk) begin
        if (loaded) begin
            cycleCount <= cycleCount + 1;
            if (cycleCount >= cycleLimit) begin
                $display("Timeout after %0d cycles, the test sequence did not finish",
                         cycleCount);
                $display("Errors found");
                $fatal(1);
            end
        end
    end

    initial begin
        rst        = 1'b1;
        clkEn      = 1'b0;
        readReq    = '0;
        issueReq   = '0;
        retireReq  = '0;
        stackReq   = '0;
        waitA      = '0;
        waitB      = '0;
        waitAValid = 1'b0;
        waitBValid = 1'b0;
        loadTests();
        cycleLimit = steps.size() * 4 + 20;
        loaded     = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        foreach (steps[i]) begin
            @(posedge clk);
            applyStep(steps[i]);
            @(posedge clk);                   // DUT samples the step here
            applyIdle();
            @(negedge clk);
            checkStep(stepNames[i], steps[i]);
        end
        @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule : ScoreboardTb

/* testbench/scoreboard_tests.txt */
# name en rA wrA dA aHot rB bAdr iA iAdr iB iBdr ld ldHot wb wbHot adj swb srd sis
#   wA wAv wB wBv expDirty expToBeWritten expToBeRead stallA stallB (all hex)
reset_idle     1 0 0 0 0000 0 0 0 0 0 0 0 0000 0 0000 0 0 0 0 2 1 5 1 0000 0000 0000 0 0
read_a_dirty   1 1 1 1 0004 0 0 0 0 0 0 0 0000 0 0000 0 0 0 0 2 1 2 1 0004 0004 0004 1 1
read_b         1 0 0 0 0000 1 5 0 0 0 0 0 0000 0 0000 0 0 0 0 5 1 5 1 0004 0004 0024 0 0
issue_b        1 0 0 0 0000 0 0 0 0 1 5 0 0000 0 0000 0 0 0 0 2 0 2 0 0004 0004 0004 0 0
read_a_clean   1 1 0 0 0008 0 0 0 0 0 0 0 0000 0 0000 0 0 0 0 3 1 3 1 0004 0004 000c 0 0
replay_a       1 0 0 0 0000 0 0 1 3 1 2 0 0000 0 0000 0 0 0 0 2 1 3 1 0004 0004 0008 1 0
issue_a        1 0 0 0 0000 0 0 1 3 0 0 0 0000 0 0000 0 0 0 0 3 1 3 1 0004 0004 0000 0 0
read_issue_a   1 1 0 0 0004 0 0 1 2 0 0 0 0000 0 0000 0 0 0 0 2 0 2 0 0004 0004 0004 0 0
write_wb_same  1 1 1 1 0004 0 0 0 0 0 0 0 0000 1 0004 0 0 0 0 2 1 2 1 0004 0004 0004 1 1
writeback      1 0 0 0 0000 0 0 0 0 0 0 0 0000 1 0004 0 0 0 0 2 1 2 1 0000 0000 0004 0 0
issue_a_r2     1 0 0 0 0000 0 0 1 2 0 0 0 0000 0 0000 0 0 0 0 2 1 2 1 0000 0000 0000 0 0
read_a_write   1 1 1 0 0080 0 0 0 0 0 0 0 0000 0 0000 0 0 0 0 7 1 7 1 0000 0080 0080 1 1
load           1 0 0 0 0000 0 0 0 0 0 0 1 0080 0 0000 0 0 0 0 7 1 7 1 0000 0000 0080 0 0
issue_b_r7     1 0 0 0 0000 0 0 0 0 1 7 0 0000 0 0000 0 0 0 0 7 1 7 1 0000 0000 0000 0 0
stack_adj1     1 0 0 0 0000 0 0 0 0 0 0 0 0000 0 0000 1 0 0 0 e 1 e 1 0000 4000 0000 1 1
stack_adj2     1 0 0 0 0000 0 0 0 0 0 0 0 0000 0 0000 1 0 0 0 e 1 e 1 4000 4000 0000 1 1
stack_adj_wb   1 0 0 0 0000 0 0 0 0 0 0 0 0000 0 0000 1 1 0 0 e 1 e 1 4000 4000 0000 1 1
stack_wb1      1 0 0 0 0000 0 0 0 0 0 0 0 0000 0 0000 0 1 0 0 e 1 e 1 0000 4000 0000 1 1
stack_wb2      1 0 0 0 0000 0 0 0 0 0 0 0 0000 0 0000 0 1 0 0 e 1 e 1 0000 0000 0000 0 0
stack_read     1 0 0 0 0000 0 0 0 0 0 0 0 0000 0 0000 0 0 1 0 e 1 e 1 0000 0000 4000 0 0
stack_rd_iss   1 0 0 0 0000 0 0 0 0 0 0 0 0000 0 0000 0 0 1 1 e 1 e 1 0000 0000 4000 0 0
stack_issue    1 0 0 0 0000 0 0 0 0 0 0 0 0000 0 0000 0 0 0 1 e 1 e 1 0000 0000 0000 0 0
gated_events   0 1 1 1 0010 1 9 0 0 0 0 0 0000 0 0000 1 0 1 0 4 1 4 1 0000 0000 0000 0 0
read_a_r4      1 1 1 0 0010 0 0 0 0 0 0 0 0000 0 0000 0 0 0 0 4 1 4 1 0000 0010 0010 1 1
gated_clear    0 0 0 0 0000 0 0 1 4 0 0 0 0000 1 0010 0 0 0 0 4 1 4 0 0000 0010 0010 1 0
final_clear    1 0 0 0 0000 0 0 1 4 0 0 0 0000 1 0010 0 0 0 0 4 1 4 1 0000 0000 0000 0 0

/* src.f */
hw/ScoreboardPkg.sv
hw/RegisterStateCell.sv
hw/StackStatus.sv
hw/HazardCheck.sv
hw/RegisterStatus.sv
hw/ScoreboardTop.sv
testbench/ScoreboardTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the scoreboard testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ScoreboardTb \
    -f src.f \
    -Mdir obj_dir

simOutput=$(./obj_dir/VScoreboardTb 2>&1 || true)
echo "$simOutput"

if grep -qx "No errors" <<< "$simOutput"; then
    exit 0
fi
exit 1
